// ==== include/his_config.svh ====
`ifndef HIS_CONFIG_SVH
`define HIS_CONFIG_SVH

// tdc bin address width
// 16 bins by default
`define HIS_BIN_BITS 4

// pixels sharing one histogram bank
`define HIS_PIXEL_NUM 4

// pixel index width
// must cover HIS_PIXEL_NUM
`define HIS_PIXEL_BITS 2

// hits taken per pixel before moving on
`define HIS_DATA_NUM 4

// acquisitions that make up one frame
`define HIS_ACQ_NUM 3

// width of one bin count
// one frame is 48 hits so no saturation is needed
`define HIS_COUNT_BITS 8

`endif

// ==== run_sim.sh ====
#!/bin/sh
# build and run the histogram builder testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -Wno-fatal --top-module his_builder_tb -f sim.f \
    -o his_builder_sim > build.log 2>&1 \
    && ./obj_dir/his_builder_sim > sim.log 2>&1 \
    || { cat build.log; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Test FAILED" sim.log && { echo "simulation reported failure"; exit 1; } || exit 0

// ==== sim.f ====
+incdir+include
source/his_pkg.sv
source/his_counter_fsm.sv
source/bin_accumulator.sv
source/his_bank_mem.sv
source/his_readout.sv
source/his_builder_top.sv
tests/his_builder_tb.sv

// ==== source/bin_accumulator.sv ====
`timescale 1ns/10ps
`include "his_config.svh"

module bin_accumulator (
    input  logic                clk,
    input  logic                res,
    input  logic                wr_en,
    input  his_pkg::bin_addr_t  addr,
    input  his_pkg::pixel_idx_t hit_pixel,
    input  logic                his_num,
    output his_pkg::mem_addr_t  acc_rd_addr,
    output logic                acc_rd_bank,
    input  his_pkg::bin_count_t acc_rd_data,
    output logic                acc_wr_en,
    output logic                acc_wr_bank,
    output his_pkg::mem_addr_t  acc_wr_addr,
    output his_pkg::bin_count_t acc_wr_data
);

    import his_pkg::*;

    // stage one, hit whose read is in flight
    logic       s1_valid;
    mem_addr_t  s1_addr;
    logic       s1_bank;

    // copy of the write issued last cycle
    logic       fw_valid;
    mem_addr_t  fw_addr;
    logic       fw_bank;
    bin_count_t fw_data;

    // forward select and the count being incremented
    logic       fw_hit;
    bin_count_t base_cnt;

    // read goes out in the same cycle as the hit
    // word address is pixel then bin
    assign acc_rd_addr = {hit_pixel, addr};
    // bank tag taken from the bank being filled right now
    assign acc_rd_bank = his_num;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s1_valid <= 1'b0;
            fw_valid <= 1'b0;
        end else begin
            s1_valid <= wr_en;
            fw_valid <= s1_valid;
        end
    end

    // payload follows the valid bits without reset
    always_ff @(posedge clk) begin
        s1_addr <= acc_rd_addr;
        s1_bank <= acc_rd_bank;
        fw_addr <= s1_addr;
        fw_bank <= s1_bank;
        fw_data <= acc_wr_data;
    end

    // ram read raced the previous write on the same word
    // bank has to match too, a swap may sit between two hits
    assign fw_hit = fw_valid && (fw_addr == s1_addr) && (fw_bank == s1_bank);

    assign base_cnt = fw_hit ? fw_data : acc_rd_data;

    // stage two writes back one cycle after the read
    assign acc_wr_en   = s1_valid;
    assign acc_wr_addr = s1_addr;
    // old bank stays the target for hits issued before the swap
    assign acc_wr_bank = s1_bank;
    assign acc_wr_data = base_cnt + 1'b1;

endmodule

// ==== source/his_bank_mem.sv ====
`timescale 1ns/10ps
`include "his_config.svh"

module his_bank_mem (
    input  logic                clk,
    input  his_pkg::mem_addr_t  acc_rd_addr,
    input  logic                acc_rd_bank,
    output his_pkg::bin_count_t acc_rd_data,
    input  logic                acc_wr_en,
    input  logic                acc_wr_bank,
    input  his_pkg::mem_addr_t  acc_wr_addr,
    input  his_pkg::bin_count_t acc_wr_data,
    input  logic                his_num,
    input  logic                ro_rd_en,
    input  his_pkg::mem_addr_t  ro_rd_addr,
    output his_pkg::bin_count_t ro_rd_data,
    input  logic                ro_clr_en
);

    import his_pkg::*;

    localparam int DEPTH = 1 << (`HIS_PIXEL_BITS + `HIS_BIN_BITS);

    // two banks, index 0/1 is the bank number
    bin_count_t mem [2][DEPTH];

    // readout always looks at the bank not being filled
    logic ro_bank;
    assign ro_bank = ~his_num;

    always_ff @(posedge clk) begin
        // accumulator update into the tagged bank
        if (acc_wr_en) begin
            mem[acc_wr_bank][acc_wr_addr] <= acc_wr_data;
        end
        // clear comes last and reads below still see the old word
        if (ro_clr_en) begin
            mem[ro_bank][ro_rd_addr] <= '0;
        end
        // registered reads
        acc_rd_data <= mem[acc_rd_bank][acc_rd_addr];
        if (ro_rd_en) begin
            ro_rd_data <= mem[ro_bank][ro_rd_addr];
        end
    end

endmodule

// ==== source/his_builder_top.sv ====
`timescale 1ns/10ps
`include "his_config.svh"

module his_builder_top (
    input  logic                clk,
    input  logic                res,
    input  logic                wr_en,
    input  his_pkg::bin_addr_t  addr,
    output logic                his_num,
    output logic                rd_valid,
    output his_pkg::mem_addr_t  rd_addr,
    output his_pkg::bin_count_t rd_count,
    output logic                overrun
);

    import his_pkg::*;

    // counter to accumulator and readout
    pixel_idx_t hit_pixel;
    logic       frame_done;

    // accumulator side of the banks
    mem_addr_t  acc_rd_addr;
    logic       acc_rd_bank;
    bin_count_t acc_rd_data;
    logic       acc_wr_en;
    logic       acc_wr_bank;
    mem_addr_t  acc_wr_addr;
    bin_count_t acc_wr_data;

    // readout side of the banks
    logic       ro_rd_en;
    mem_addr_t  ro_rd_addr;
    bin_count_t ro_rd_data;
    logic       ro_clr_en;

    // tags each hit with its pixel, flags frame end
    his_counter_fsm u_counter (
        .clk        (clk),
        .res        (res),
        .wr_en      (wr_en),
        .hit_pixel  (hit_pixel),
        .frame_done (frame_done),
        .his_num    (his_num)
    );

    bin_accumulator u_acc (
        .clk         (clk),
        .res         (res),
        .wr_en       (wr_en),
        .addr        (addr),
        .hit_pixel   (hit_pixel),
        .his_num     (his_num),
        .acc_rd_addr (acc_rd_addr),
        .acc_rd_bank (acc_rd_bank),
        .acc_rd_data (acc_rd_data),
        .acc_wr_en   (acc_wr_en),
        .acc_wr_bank (acc_wr_bank),
        .acc_wr_addr (acc_wr_addr),
        .acc_wr_data (acc_wr_data)
    );

    // ping-pong banks
    his_bank_mem u_mem (
        .clk         (clk),
        .acc_rd_addr (acc_rd_addr),
        .acc_rd_bank (acc_rd_bank),
        .acc_rd_data (acc_rd_data),
        .acc_wr_en   (acc_wr_en),
        .acc_wr_bank (acc_wr_bank),
        .acc_wr_addr (acc_wr_addr),
        .acc_wr_data (acc_wr_data),
        .his_num     (his_num),
        .ro_rd_en    (ro_rd_en),
        .ro_rd_addr  (ro_rd_addr),
        .ro_rd_data  (ro_rd_data),
        .ro_clr_en   (ro_clr_en)
    );

    // streams and clears the finished bank
    his_readout u_ro (
        .clk        (clk),
        .res        (res),
        .frame_done (frame_done),
        .ro_rd_en   (ro_rd_en),
        .ro_rd_addr (ro_rd_addr),
        .ro_rd_data (ro_rd_data),
        .ro_clr_en  (ro_clr_en),
        .rd_valid   (rd_valid),
        .rd_addr    (rd_addr),
        .rd_count   (rd_count),
        .overrun    (overrun)
    );

endmodule

// ==== source/his_counter_fsm.sv ====
`timescale 1ns/10ps
`include "his_config.svh"

module his_counter_fsm (
    input  logic               clk,
    input  logic               res,
    input  logic               wr_en,
    output his_pkg::pixel_idx_t hit_pixel,
    output logic               frame_done,
    output logic               his_num
);

    import his_pkg::*;

    // counter widths, one spare bit so a count of 1 still gets a bit
    localparam int IN_W  = $clog2(`HIS_DATA_NUM + 1);
    localparam int ACQ_W = $clog2(`HIS_ACQ_NUM + 1);

    // hits seen for the current pixel
    logic [IN_W-1:0]  input_cnt;
    // pixel currently being served
    pixel_idx_t       pixel_cnt;
    // acquisition within the frame
    logic [ACQ_W-1:0] acq_cnt;

    // wrap conditions, each one gates the next counter up
    logic input_last;
    logic pixel_last;
    logic acq_last;
    logic frame_last;

    assign input_last = (input_cnt == IN_W'(`HIS_DATA_NUM - 1));
    assign pixel_last = (pixel_cnt == pixel_idx_t'(`HIS_PIXEL_NUM - 1));
    assign acq_last   = (acq_cnt == ACQ_W'(`HIS_ACQ_NUM - 1));

    // last hit of the last pixel of the last acquisition
    assign frame_last = wr_en && input_last && pixel_last && acq_last;

    // present hit belongs to the pixel the counters point at
    assign hit_pixel = pixel_cnt;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            input_cnt <= '0;
            pixel_cnt <= '0;
            acq_cnt   <= '0;
        end else if (wr_en) begin
            if (input_last) begin
                input_cnt <= '0;
                // pixel advances once its hits are in
                if (pixel_last) begin
                    pixel_cnt <= '0;
                    // all pixels done, next acquisition
                    if (acq_last) begin
                        acq_cnt <= '0;
                    end else begin
                        acq_cnt <= acq_cnt + 1'b1;
                    end
                end else begin
                    pixel_cnt <= pixel_cnt + 1'b1;
                end
            end else begin
                input_cnt <= input_cnt + 1'b1;
            end
        end
    end

    // frame end pulse and bank swap share one edge
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            frame_done <= 1'b0;
            his_num    <= 1'b0;
        end else begin
            frame_done <= frame_last;
            if (frame_last) begin
                his_num <= ~his_num;
            end
        end
    end

endmodule

// ==== source/his_pkg.sv ====
`include "his_config.svh"

package his_pkg;

    // one tdc bin number as delivered with a hit
    typedef logic [`HIS_BIN_BITS-1:0] bin_addr_t;

    // pixel number inside the array
    typedef logic [`HIS_PIXEL_BITS-1:0] pixel_idx_t;

    // bank word address
    // upper bits pixel, lower bits bin
    typedef logic [`HIS_PIXEL_BITS+`HIS_BIN_BITS-1:0] mem_addr_t;

    // one histogram count
    typedef logic [`HIS_COUNT_BITS-1:0] bin_count_t;

endpackage

// ==== source/his_readout.sv ====
`timescale 1ns/10ps
`include "his_config.svh"

module his_readout (
    input  logic                clk,
    input  logic                res,
    input  logic                frame_done,
    output logic                ro_rd_en,
    output his_pkg::mem_addr_t  ro_rd_addr,
    input  his_pkg::bin_count_t ro_rd_data,
    output logic                ro_clr_en,
    output logic                rd_valid,
    output his_pkg::mem_addr_t  rd_addr,
    output his_pkg::bin_count_t rd_count,
    output logic                overrun
);

    import his_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_drain,
        st_scan
    } ro_state_t;

    ro_state_t state;
    // drain cycles done
    logic      drain_cnt;
    // next word to read
    mem_addr_t word_cnt;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state     <= st_idle;
            drain_cnt <= 1'b0;
            word_cnt  <= '0;
        end else begin
            case (state)
                st_idle: begin
                    // a frame during a scan is dropped here
                    if (frame_done) begin
                        state     <= st_drain;
                        drain_cnt <= 1'b0;
                    end
                end
                st_drain: begin
                    // let the last accumulator writes land first
                    drain_cnt <= 1'b1;
                    if (drain_cnt) begin
                        state    <= st_scan;
                        word_cnt <= '0;
                    end
                end
                st_scan: begin
                    word_cnt <= word_cnt + 1'b1;
                    if (word_cnt == '1) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // one read per scan cycle, cleared on the same edge
    assign ro_rd_en   = (state == st_scan);
    assign ro_rd_addr = word_cnt;
    assign ro_clr_en  = ro_rd_en;

    // valid and address lag the read by one cycle like the data
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            rd_valid <= 1'b0;
            overrun  <= 1'b0;
        end else begin
            rd_valid <= ro_rd_en;
            // sticky until reset
            if (frame_done && (state != st_idle)) begin
                overrun <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        rd_addr <= ro_rd_addr;
    end

    // ram output register already lines up with rd_valid
    assign rd_count = ro_rd_data;

endmodule

// ==== tests/his_builder_tb.sv ====
`timescale 1ns/10ps
`include "his_config.svh"

module his_builder_tb;

    import his_pkg::*;

    localparam int FRAME_HITS = `HIS_DATA_NUM * `HIS_PIXEL_NUM * `HIS_ACQ_NUM;
    localparam int WORDS = 1 << (`HIS_PIXEL_BITS + `HIS_BIN_BITS);
    // spaced frame takes two cycles per hit
    // readout is drain plus scan
    localparam int FRAME_CYC = 2 * FRAME_HITS;
    localparam int RO_CYC = WORDS + 8;
    // five tests and two flush frames
    localparam int WATCHDOG_CYC = 7 * (FRAME_CYC + RO_CYC + 250);

    logic       clk;
    logic       res;
    logic       wr_en;
    bin_addr_t  addr;
    logic       his_num;
    logic       rd_valid;
    mem_addr_t  rd_addr;
    bin_count_t rd_count;
    logic       overrun;

    // reference histogram indexed by bank then word
    bin_count_t model [2][WORDS];
    logic       fill_bank;
    // bank the readout used on the previous edge
    logic       ro_bank_d;
    int         hit_cnt;
    int         hit_word;
    int         ro_words;
    mem_addr_t  exp_addr;
    logic       prev_valid;
    logic       check_en;
    int         errors;
    string      test_name;
    integer     seed;

    his_builder_top dut0 (
        .clk      (clk),
        .res      (res),
        .wr_en    (wr_en),
        .addr     (addr),
        .his_num  (his_num),
        .rd_valid (rd_valid),
        .rd_addr  (rd_addr),
        .rd_count (rd_count),
        .overrun  (overrun)
    );

    always #5 clk = ~clk;

    // monitor and reference model see pre-edge values
    always @(posedge clk) begin
        if (!res) begin
            fill_bank  = 1'b0;
            ro_bank_d  = 1'b1;
            hit_cnt    = 0;
            exp_addr   = '0;
            prev_valid = 1'b0;
        end else begin
            // every stream starts at word 0
            if (rd_valid && !prev_valid) begin
                exp_addr = '0;
            end
            if (!rd_valid && prev_valid) begin
                assert (exp_addr === '0) else begin
                    $display("%s: readout stream stopped before word %0d", test_name, exp_addr);
                    errors++;
                end
            end
            if (rd_valid) begin
                assert (rd_addr === exp_addr) else begin
                    $display("[ERROR] %s rd_addr expected %0d actual %0d",
                             test_name, exp_addr, rd_addr);
                    errors++;
                end
                // flush words hold whatever the banks powered up with
                if (check_en) begin
                    assert (rd_count === model[ro_bank_d][rd_addr]) else begin
                        $display("[ERROR] %s word %0d expected %0d actual %0d", test_name,
                                 rd_addr, model[ro_bank_d][rd_addr], rd_count);
                        errors++;
                    end
                end
                // word is cleared once read
                model[ro_bank_d][rd_addr] = '0;
                exp_addr = exp_addr + mem_addr_t'(1);
                ro_words++;
            end
            prev_valid = rd_valid;
            // readout serves the bank not being filled
            ro_bank_d = ~fill_bank;
            if (wr_en) begin
                // pixel follows from hit position
                // DATA_NUM hits per pixel in turn
                hit_word = ((hit_cnt / `HIS_DATA_NUM) % `HIS_PIXEL_NUM) * (1 << `HIS_BIN_BITS)
                           + int'(addr);
                model[fill_bank][hit_word] = model[fill_bank][hit_word] + bin_count_t'(1);
                hit_cnt++;
                if (hit_cnt == FRAME_HITS) begin
                    hit_cnt   = 0;
                    fill_bank = ~fill_bank;
                end
            end
        end
    end

    task automatic check_level(input string what, input logic actual, input logic expected);
        assert (actual === expected) else begin
            $display("[ERROR] %s %s expected %0b actual %0b", test_name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic clear_model();
        for (int b = 0; b < 2; b++) begin
            for (int w = 0; w < WORDS; w++) begin
                model[b][w] = '0;
            end
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        res   <= 1'b0;
        wr_en <= 1'b0;
        repeat (3) begin
            @(negedge clk);
            check_level("rd_valid in reset", rd_valid, 1'b0);
            check_level("overrun in reset", overrun, 1'b0);
            check_level("his_num in reset", his_num, 1'b0);
        end
        @(posedge clk);
        res <= 1'b1;
    endtask

    // one hit followed by gap idle cycles
    task automatic drive_hit(input bin_addr_t bin, input int gap);
        @(posedge clk);
        wr_en <= 1'b1;
        addr  <= bin;
        repeat (gap) begin
            @(posedge clk);
            wr_en <= 1'b0;
        end
    endtask

    task automatic release_bus();
        @(posedge clk);
        wr_en <= 1'b0;
    endtask

    task automatic random_hits(input int count, input int gap);
        for (int i = 0; i < count; i++) begin
            drive_hit(bin_addr_t'($random(seed)), gap);
        end
        release_bus();
    endtask

    // one full stream after start and then quiet
    task automatic wait_readout(input int start);
        int waited;
        waited = 0;
        while (ro_words < start + WORDS && waited < FRAME_CYC + RO_CYC) begin
            @(negedge clk);
            waited++;
        end
        repeat (8) @(negedge clk);
        assert (ro_words == start + WORDS) else begin
            $display("[ERROR] %s readout words expected %0d actual %0d",
                     test_name, WORDS, ro_words - start);
            errors++;
        end
    endtask

    task automatic reset_state();
        test_name = "reset_state";
        apply_reset();
        @(negedge clk);
        check_level("rd_valid after reset", rd_valid, 1'b0);
        check_level("overrun after reset", overrun, 1'b0);
        check_level("his_num after reset", his_num, 1'b0);
        // first frame is also the first flush
        for (int i = 0; i < FRAME_HITS; i++) begin
            drive_hit(bin_addr_t'($random(seed)), 1);
            @(negedge clk);
            check_level("rd_valid before frame end", rd_valid, 1'b0);
        end
        check_level("his_num after first frame", his_num, 1'b1);
    endtask

    // second flush reads the other bank
    // both banks end up zero
    task automatic flush_banks();
        test_name = "flush";
        wait_readout(0);
        random_hits(FRAME_HITS, 1);
        wait_readout(WORDS);
        clear_model();
        check_en = 1'b1;
    endtask

    task automatic single_frame();
        int   start;
        logic bank0;
        test_name = "single_frame";
        start = ro_words;
        bank0 = his_num;
        random_hits(FRAME_HITS, 1);
        wait_readout(start);
        check_level("his_num", his_num, ~bank0);
    endtask

    task automatic same_bin_burst();
        int   start;
        logic bank0;
        test_name = "same_bin_burst";
        start = ro_words;
        bank0 = his_num;
        // two long runs
        // each pixel word gets its hits back to back
        for (int i = 0; i < FRAME_HITS; i++) begin
            drive_hit((i < FRAME_HITS / 2) ? bin_addr_t'(5) : bin_addr_t'(9), 0);
        end
        release_bus();
        wait_readout(start);
        check_level("his_num", his_num, ~bank0);
    endtask

    task automatic bank_clear();
        logic bank0;
        test_name = "bank_clear";
        bank0 = his_num;
        random_hits(FRAME_HITS, 1);
        wait_readout(ro_words);
        random_hits(FRAME_HITS, 1);
        wait_readout(ro_words);
        check_level("his_num after two frames", his_num, bank0);
    endtask

    task automatic overrun_flag();
        int start;
        test_name = "overrun_flag";
        check_level("overrun before", overrun, 1'b0);
        start = ro_words;
        // second frame follows with no idle cycle
        // and ends mid scan
        random_hits(2 * FRAME_HITS, 0);
        repeat (2) @(negedge clk);
        check_level("overrun after second frame", overrun, 1'b1);
        wait_readout(start);
        // the second frame's stream is skipped
        repeat (RO_CYC) @(negedge clk);
        assert (ro_words == start + WORDS) else begin
            $display("[ERROR] %s readout words expected %0d actual %0d",
                     test_name, WORDS, ro_words - start);
            errors++;
        end
        check_level("overrun held", overrun, 1'b1);
        apply_reset();
        @(negedge clk);
        check_level("overrun after reset", overrun, 1'b0);
    endtask

    initial begin
        clk       = 1'b0;
        res       = 1'b0;
        wr_en     = 1'b0;
        addr      = '0;
        seed      = 72001;
        errors    = 0;
        ro_words  = 0;
        check_en  = 1'b0;
        test_name = "init";
        clear_model();
        reset_state();
        flush_banks();
        single_frame();
        same_bin_burst();
        bank_clear();
        overrun_flag();
        $display("run complete, errors: %0d", errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // ends a run that stops making progress
    initial begin
        repeat (WATCHDOG_CYC) @(posedge clk);
        $display("timeout: tests did not finish within %0d cycles", WATCHDOG_CYC);
        $display("Test FAILED");
        $finish;
    end

endmodule
